/* vlog.f */
+incdir+.
icmu_pkg.sv
irq_pending_arbiter.sv
irq_statistics.sv
irq_dispatcher.sv
icmu_top.sv
tb_icmu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_icmu \
    -o sim_icmu

# The log decides the verdict, so a fatal exit must not stop the script here
./obj_dir/sim_icmu > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

echo "simulation passed"

/* tb_icmu.sv */
// Interrupt controller testbench
`timescale 1ns/1ps
`default_nettype none

`include "icmu_settings.svh"

module tb_icmu;

    import icmu_pkg::*;

    localparam int CYCLE_LIMIT = 2000;

    typedef struct packed {
        irq_vec_t      pending;
        irq_dispatch_t dispatch;
        irq_vec_t      history;
        irq_counts_t   counts;
    } model_state_t;

    logic          clk;
    logic          reset_n;
    irq_vec_t      lines;
    debug_ctrl_t   debug;
    irq_dispatch_t dispatch;
    irq_vec_t      history;
    irq_counts_t   counts;

    model_state_t  model = '0;
    logic          wrap_seen = 1'b0;
    int            cycle_count = 0;
    logic [31:0]   rng_state = 32'd16436;

    icmu_top icmu_top_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .lines    (lines),
        .debug    (debug),
        .dispatch (dispatch),
        .history  (history),
        .counts   (counts)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // One clock of the controller, straight from the pending, grant and dispatch rules
    function automatic model_state_t step_model(input model_state_t s, input irq_vec_t ln,
                                                input debug_ctrl_t dbg);
        model_state_t n;
        logic         cand_valid;
        irq_id_t      cand_id;
        logic         take;
        n = s;
        cand_valid = 1'b0;
        cand_id = '0;
        for (int i = 0; i < `ICMU_INT_COUNT; i++) begin
            if (s.pending[i] && !cand_valid) begin
                cand_valid = 1'b1;
                cand_id = irq_id_t'(i);
            end
        end
        take = cand_valid && (!dbg.mode || (dbg.step && !dbg.override));
        if (dbg.mode && dbg.override) begin
            n.dispatch.valid = 1'b1;
            n.dispatch.id = dbg.force_id;
        end else if (take) begin
            n.dispatch.valid = 1'b1;
            n.dispatch.id = cand_id;
        end else begin
            n.dispatch.valid = 1'b0;
        end
        n.pending = s.pending | ln;
        if (take) begin
            n.pending[cand_id] = 1'b0;
        end
        n.history = s.history | ln;
        for (int i = 0; i < `ICMU_INT_COUNT; i++) begin
            if (ln[i] && !s.pending[i]) begin
                n.counts[i] = s.counts[i] + irq_count_t'(1);
            end
        end
        return n;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_dispatch(input irq_dispatch_t got, input irq_dispatch_t exp,
                                  input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s dispatch got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_history(input irq_vec_t got, input irq_vec_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s history got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_counts(input irq_counts_t got, input irq_counts_t exp,
                                input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s counts got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic debug_ctrl_t make_debug(input logic mode, input logic step,
                                               input logic override, input irq_id_t force_id);
        debug_ctrl_t d;
        d.mode = mode;
        d.step = step;
        d.override = override;
        d.force_id = force_id;
        return d;
    endfunction

    task automatic drive_inputs(input irq_vec_t ln, input debug_ctrl_t dbg);
        @(posedge clk);
        #1;
        lines = ln;
        debug = dbg;
    endtask

    task automatic idle_for(input int n);
        repeat (n) drive_inputs('0, '0);
    endtask

    task automatic expect_dispatch_id(input irq_id_t id);
        irq_dispatch_t exp_d;
        exp_d.valid = 1'b1;
        exp_d.id = id;
        @(negedge clk);
        check_dispatch(dispatch, exp_d, "lowest first");
    endtask

    // Model advances on the same edges as the DUT
    always @(posedge clk or negedge reset_n) begin
        model_state_t next;
        if (!reset_n) begin
            model = '0;
        end else begin
            next = step_model(model, lines, debug);
            for (int i = 0; i < `ICMU_INT_COUNT; i++) begin
                if (model.counts[i] == '1 && next.counts[i] == '0) begin
                    wrap_seen = 1'b1;
                end
            end
            model = next;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        check_dispatch(dispatch, model.dispatch, "cycle model");
        check_history(history, model.history, "cycle model");
        check_counts(counts, model.counts, "cycle model");
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        logic [31:0] r;
        reset_n = 1'b0;
        lines = '0;
        debug = '0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        idle_for(10);
        @(negedge clk);
        check_dispatch(dispatch, '0, "idle after reset");
        check_history(history, '0, "idle after reset");
        check_counts(counts, '0, "idle after reset");

        // Three lines at once, one id per cycle
        drive_inputs(8'b0001_0110, '0);
        drive_inputs('0, '0);
        @(negedge clk);
        expect_dispatch_id(3'd1);
        expect_dispatch_id(3'd2);
        expect_dispatch_id(3'd4);
        idle_for(5);
        drive_inputs(8'b1110_0001, '0);
        drive_inputs('0, '0);
        idle_for(8);

        // Debug hold, then single steps
        drive_inputs(8'b1100_1000, make_debug(1'b1, 1'b0, 1'b0, 3'd0));
        repeat (6) drive_inputs('0, make_debug(1'b1, 1'b0, 1'b0, 3'd0));
        repeat (3) begin
            drive_inputs('0, make_debug(1'b1, 1'b1, 1'b0, 3'd0));
            repeat (3) drive_inputs('0, make_debug(1'b1, 1'b0, 1'b0, 3'd0));
        end
        idle_for(4);

        // Forced ids leave pending alone
        drive_inputs(8'b0011_0000, make_debug(1'b1, 1'b0, 1'b0, 3'd0));
        repeat (4) drive_inputs('0, make_debug(1'b1, 1'b0, 1'b1, 3'd6));
        repeat (2) drive_inputs('0, make_debug(1'b1, 1'b1, 1'b1, 3'd2));
        idle_for(8);

        // Line 7 held long enough for its counter to wrap
        drive_inputs(8'b0000_0100, '0);
        repeat (600) drive_inputs(8'h80, '0);
        idle_for(5);

        repeat (800) begin
            rng_state = lcg_next(rng_state);
            r = rng_state;
            drive_inputs(r[31:24] & r[23:16], make_debug(r[12], r[11], r[10] & r[9], r[8:6]));
        end
        idle_for(5);

        if (!wrap_seen) begin
            $display("no event counter wrapped during the run");
            abort_run();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* icmu_top.sv */
// Interrupt controller top level
`timescale 1ns/1ps
`default_nettype none

module icmu_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  icmu_pkg::irq_vec_t      lines,
    input  icmu_pkg::debug_ctrl_t   debug,
    output icmu_pkg::irq_dispatch_t dispatch,
    output icmu_pkg::irq_vec_t      history,
    output icmu_pkg::irq_counts_t   counts
);

    import icmu_pkg::*;

    irq_candidate_t candidate;
    irq_vec_t       pending;
    logic           grant;

    // Pending bits and lowest-index selection
    irq_pending_arbiter irq_pending_arbiter_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .lines     (lines),
        .grant     (grant),
        .pending   (pending),
        .candidate (candidate)
    );

    // Observes the same lines, results go straight out
    irq_statistics irq_statistics_i (
        .clk     (clk),
        .reset_n (reset_n),
        .lines   (lines),
        .pending (pending),
        .history (history),
        .counts  (counts)
    );

    irq_dispatcher irq_dispatcher_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .candidate (candidate),
        .debug     (debug),
        .grant     (grant),
        .dispatch  (dispatch)
    );

endmodule

`default_nettype wire

/* irq_dispatcher.sv */
// Interrupt dispatcher with debug controls
`timescale 1ns/1ps
`default_nettype none

module irq_dispatcher (
    input  logic                     clk,
    input  logic                     reset_n,
    input  icmu_pkg::irq_candidate_t candidate,
    input  icmu_pkg::debug_ctrl_t    debug,
    output logic                     grant,
    output icmu_pkg::irq_dispatch_t  dispatch
);

    import icmu_pkg::*;

    logic          force_active;
    logic          dispatch_allowed;
    irq_dispatch_t dispatch_next;

    // Override only counts in debug mode
    assign force_active = debug.mode && debug.override;

    // Single step in debug mode
    assign dispatch_allowed = !debug.mode || (!debug.override && debug.step);

    assign grant = candidate.valid && dispatch_allowed;

    // Override takes precedence over step
    always_comb begin
        dispatch_next.valid = 1'b0;
        dispatch_next.id    = dispatch.id;
        if (force_active) begin
            dispatch_next.valid = 1'b1;
            dispatch_next.id    = debug.force_id;
        end else if (grant) begin
            dispatch_next.valid = 1'b1;
            dispatch_next.id    = candidate.id;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dispatch <= '0;
        end else begin
            dispatch <= dispatch_next;
        end
    end

    // Forced ids never clear a pending bit
    a_no_grant_on_override: assert property (
        @(posedge clk) disable iff (!reset_n)
        force_active |-> !grant
    );

endmodule

`default_nettype wire

/* irq_statistics.sv */
// Interrupt line statistics
`timescale 1ns/1ps
`default_nettype none

`include "icmu_settings.svh"

module irq_statistics (
    input  logic                  clk,
    input  logic                  reset_n,
    input  icmu_pkg::irq_vec_t    lines,
    input  icmu_pkg::irq_vec_t    pending,
    output icmu_pkg::irq_vec_t    history,
    output icmu_pkg::irq_counts_t counts
);

    import icmu_pkg::*;

    // Line high while its pending bit is still clear
    irq_vec_t count_event;

    assign count_event = lines & ~pending;

    // Sticky record of every line ever seen
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            history <= '0;
        end else begin
            history <= history | lines;
        end
    end

    // Per-line counters, wrap on overflow
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < `ICMU_INT_COUNT; i++) begin
                if (count_event[i]) begin
                    counts[i] <= counts[i] + irq_count_t'(1);
                end
            end
        end
    end

    // History bits never drop outside reset
    a_history_sticky: assert property (
        @(posedge clk) disable iff (!reset_n)
        ($past(history) & ~history) == '0
    );

endmodule

`default_nettype wire

/* irq_pending_arbiter.sv */
// Pending interrupt arbiter
`timescale 1ns/1ps
`default_nettype none

`include "icmu_settings.svh"

module irq_pending_arbiter (
    input  logic                     clk,
    input  logic                     reset_n,
    input  icmu_pkg::irq_vec_t       lines,
    input  logic                     grant,
    output icmu_pkg::irq_vec_t       pending,
    output icmu_pkg::irq_candidate_t candidate
);

    import icmu_pkg::*;

    irq_vec_t clear_mask;
    irq_vec_t pending_next;

    // Lowest set index wins
    always_comb begin
        candidate.valid = 1'b0;
        candidate.id    = '0;
        for (int i = `ICMU_INT_COUNT - 1; i >= 0; i--) begin
            if (pending[i]) begin
                candidate.valid = 1'b1;
                candidate.id    = irq_id_t'(i);
            end
        end
    end

    // One-hot clear for the granted id
    always_comb begin
        clear_mask = '0;
        if (grant) begin
            clear_mask[candidate.id] = 1'b1;
        end
    end

    // Clear wins over a line still high
    assign pending_next = (pending | lines) & ~clear_mask;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= '0;
        end else begin
            pending <= pending_next;
        end
    end

    // Dispatcher must only grant a real candidate
    a_grant_needs_candidate: assert property (
        @(posedge clk) disable iff (!reset_n)
        grant |-> candidate.valid
    );

endmodule

`default_nettype wire

/* icmu_pkg.sv */
// Interrupt controller types
`default_nettype none

`include "icmu_settings.svh"

package icmu_pkg;

    // One bit per interrupt line
    typedef logic [`ICMU_INT_COUNT-1:0] irq_vec_t;

    // Index of a single line
    typedef logic [`ICMU_ID_W-1:0] irq_id_t;

    // Event count of one line
    typedef logic [`ICMU_COUNT_W-1:0] irq_count_t;

    // Element i belongs to line i
    typedef irq_count_t [`ICMU_INT_COUNT-1:0] irq_counts_t;

    // Arbiter result, lowest pending index
    typedef struct packed {
        logic    valid;
        irq_id_t id;
    } irq_candidate_t;

    // Debug controls from outside
    typedef struct packed {
        logic    mode;
        logic    step;
        logic    override;
        irq_id_t force_id;
    } debug_ctrl_t;

    // Registered controller output
    typedef struct packed {
        logic    valid;
        irq_id_t id;
    } irq_dispatch_t;

endpackage

`default_nettype wire

/* icmu_settings.svh */
// Interrupt controller settings
`ifndef ICMU_SETTINGS_SVH
`define ICMU_SETTINGS_SVH

// Number of level interrupt lines
`define ICMU_INT_COUNT 8

// Bits needed to name one line
`define ICMU_ID_W 3

// Width of each per-line event counter
// Wraps on overflow, cleared only by reset
`define ICMU_COUNT_W 8

`endif
